// File: pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    typedef logic [31:0] word_t;              // Pipeline word, PC and data
    typedef logic [4:0]  reg_idx_t;           // Register number

    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6,
        OP_LW   = 4'd7,
        OP_SW   = 4'd8,
        OP_BEQ  = 4'd9
    } opcode_e;

    typedef struct packed {
        opcode_e     op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [12:0] unused;                  // Spare bits, ignored by decode
    } instr_r_t;

    typedef struct packed {
        opcode_e            op;
        reg_idx_t           rd;               // Data reg for SW, first compare reg for BEQ
        reg_idx_t           rs1;
        logic signed [17:0] imm;              // Word offset for BEQ
    } instr_i_t;

    // Same 32 bits read as register form or immediate form
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,                     // Value read in decode
        FWD_WB   = 2'b01,                     // From MEM/WB
        FWD_MEM  = 2'b10                      // From EX/MEM
    } fwd_sel_e;

    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     uses_rs1;
        logic     uses_rs2;
        word_t    rs1_val;
        word_t    rs2_val;
        word_t    imm;                        // Sign-extended
        word_t    pc;
        logic     reg_write;
        logic     mem_read;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        opcode_e  op;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_out;                    // Result or memory address
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        word_t    wb_data;
    } mem_wb_t;

endpackage

`default_nettype wire

// File: hazard_unit.sv
`default_nettype none
`timescale 1ns/1ns

module hazard_unit (
    input  wire pipe_pkg::id_ex_t  id_ex,
    input  wire pipe_pkg::ex_mem_t ex_mem,
    input  wire pipe_pkg::mem_wb_t mem_wb,
    input  wire logic              branch_taken,  // Valid BEQ in execute with equal operands
    output pipe_pkg::fwd_sel_e     fwd_a,
    output pipe_pkg::fwd_sel_e     fwd_b,
    output logic                   stall,
    output logic                   flush
);
    import pipe_pkg::*;

    logic mem_hit_a, mem_hit_b;               // EX/MEM producer matches a source
    logic wb_hit_a, wb_hit_b;                 // MEM/WB producer matches a source
    logic load_hit_a, load_hit_b;             // Load in EX/MEM feeds a source

    // Later stage writes a used, nonzero source register
    function automatic logic hits(input logic vld, input logic wr, input reg_idx_t rd,
                                  input reg_idx_t src, input logic used);
        return vld && wr && (rd != 5'd0) && (rd == src) && used;
    endfunction

    assign mem_hit_a = hits(ex_mem.valid, ex_mem.reg_write, ex_mem.rd, id_ex.rs1, id_ex.uses_rs1);
    assign mem_hit_b = hits(ex_mem.valid, ex_mem.reg_write, ex_mem.rd, id_ex.rs2, id_ex.uses_rs2);
    assign wb_hit_a  = hits(mem_wb.valid, mem_wb.reg_write, mem_wb.rd, id_ex.rs1, id_ex.uses_rs1);
    assign wb_hit_b  = hits(mem_wb.valid, mem_wb.reg_write, mem_wb.rd, id_ex.rs2, id_ex.uses_rs2);

    // Load result not ready until it reaches MEM/WB
    assign load_hit_a = hits(ex_mem.valid, ex_mem.mem_read, ex_mem.rd, id_ex.rs1, id_ex.uses_rs1);
    assign load_hit_b = hits(ex_mem.valid, ex_mem.mem_read, ex_mem.rd, id_ex.rs2, id_ex.uses_rs2);

    always_comb begin
        fwd_a = FWD_NONE;
        fwd_b = FWD_NONE;
        if (mem_hit_a) begin
            fwd_a = FWD_MEM;                  // Newest value wins
        end else if (wb_hit_a) begin
            fwd_a = FWD_WB;
        end
        if (mem_hit_b) begin
            fwd_b = FWD_MEM;
        end else if (wb_hit_b) begin
            fwd_b = FWD_WB;
        end
    end

    assign stall = id_ex.valid && (load_hit_a || load_hit_b);
    assign flush = branch_taken && !stall;    // Branch waits for the stall to clear

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none
`timescale 1ns/1ns

module reg_file #(
    parameter int XLEN = 32
) (
    input  wire logic            clk,
    input  wire logic            reset_n,
    input  wire logic [4:0]      rd_addr_a,
    input  wire logic [4:0]      rd_addr_b,
    output logic      [XLEN-1:0] rd_data_a,
    output logic      [XLEN-1:0] rd_data_b,
    input  wire logic            wr_en,
    input  wire logic [4:0]      wr_addr,
    input  wire logic [XLEN-1:0] wr_data
);

    logic [XLEN-1:0] regs [32];               // x0 slot kept at zero

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write shows up on the read port
    assign rd_data_a = (rd_addr_a == 5'd0) ? '0 :
                       (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == 5'd0) ? '0 :
                       (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: fetch_decode.sv
`default_nettype none
`timescale 1ns/1ns

module fetch_decode (
    input  wire logic               clk,
    input  wire logic               reset_n,
    output pipe_pkg::word_t         fetch_pc,
    input  wire pipe_pkg::word_t    fetch_instr,   // Returned in the same cycle
    input  wire logic               stall,
    input  wire logic               flush,
    input  wire pipe_pkg::word_t    branch_target,
    output pipe_pkg::reg_idx_t      rs1_addr,
    output pipe_pkg::reg_idx_t      rs2_addr,
    input  wire pipe_pkg::word_t    rs1_data,
    input  wire pipe_pkg::word_t    rs2_data,
    output pipe_pkg::id_ex_t        id_ex
);
    import pipe_pkg::*;

    word_t   pc_q;
    logic    if_id_valid;
    instr_u  if_id_instr;                     // One word read two ways
    word_t   if_id_pc;
    opcode_e op;
    logic    is_reg;                          // Register-form ALU op
    id_ex_t  id_next;

    assign fetch_pc = pc_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pc_q        <= '0;
            if_id_valid <= 1'b0;
        end else if (flush) begin
            pc_q        <= branch_target;     // Redirect drops the younger fetch
            if_id_valid <= 1'b0;
        end else if (!stall) begin
            pc_q        <= pc_q + 32'd4;
            if_id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_instr <= fetch_instr;       // IF/ID payload
            if_id_pc    <= fetch_pc;
        end
    end

    assign op     = if_id_instr.r.op;
    assign is_reg = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};

    // SW and BEQ read their second register from the rd field
    assign rs1_addr = if_id_instr.i.rs1;      // Same bits in both forms
    assign rs2_addr = is_reg ? if_id_instr.r.rs2 :
                      (op inside {OP_SW, OP_BEQ}) ? if_id_instr.i.rd : 5'd0;

    always_comb begin
        id_next           = '0;
        id_next.valid     = if_id_valid;
        id_next.op        = op;
        id_next.rd        = if_id_instr.r.rd;
        id_next.rs1       = rs1_addr;
        id_next.rs2       = rs2_addr;
        id_next.uses_rs1  = (op != OP_NOP);
        id_next.uses_rs2  = is_reg || (op inside {OP_SW, OP_BEQ});
        id_next.rs1_val   = rs1_data;
        id_next.rs2_val   = rs2_data;
        id_next.imm       = is_reg ? '0 : {{14{if_id_instr.i.imm[17]}}, if_id_instr.i.imm};
        id_next.pc        = if_id_pc;
        id_next.reg_write = is_reg || (op inside {OP_ADDI, OP_LW});
        id_next.mem_read  = (op == OP_LW);
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            id_ex <= '0;
        end else if (flush) begin
            id_ex <= '0;                      // Bubble in place of wrong-path op
        end else if (!stall) begin
            id_ex <= id_next;                 // Stall holds the consumer
        end
    end

endmodule

`default_nettype wire

// File: execute_stage.sv
`default_nettype none
`timescale 1ns/1ns

module execute_stage #(
    parameter int XLEN = 32
) (
    input  wire logic               clk,
    input  wire logic               reset_n,
    input  wire pipe_pkg::id_ex_t   id_ex,
    input  wire pipe_pkg::fwd_sel_e fwd_a,
    input  wire pipe_pkg::fwd_sel_e fwd_b,
    input  wire pipe_pkg::ex_mem_t  ex_mem_fwd,    // Current EX/MEM as forwarding source
    input  wire pipe_pkg::mem_wb_t  mem_wb,
    input  wire logic               stall,
    output logic                    branch_taken,
    output pipe_pkg::word_t         branch_target,
    output pipe_pkg::ex_mem_t       ex_mem
);
    import pipe_pkg::*;

    logic [XLEN-1:0] op_a, op_b;              // Forwarded operands
    logic [XLEN-1:0] hold_a, hold_b;          // Operands seen during the stall cycle
    logic            held_q;                  // ID/EX was held last cycle
    logic [XLEN-1:0] alu_out;
    ex_mem_t         ex_next;

    // A producer may retire during the stall, so its value is kept here
    function automatic logic [XLEN-1:0] pick(input fwd_sel_e sel,
                                             input logic [XLEN-1:0] dec_val,
                                             input logic [XLEN-1:0] held_val,
                                             input logic held,
                                             input logic [XLEN-1:0] mem_val,
                                             input logic [XLEN-1:0] wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return held ? held_val : dec_val;
        endcase
    endfunction

    assign op_a = pick(fwd_a, id_ex.rs1_val, hold_a, held_q,
                       ex_mem_fwd.alu_out, mem_wb.wb_data);
    assign op_b = pick(fwd_b, id_ex.rs2_val, hold_b, held_q,
                       ex_mem_fwd.alu_out, mem_wb.wb_data);

    always_comb begin
        case (id_ex.op)
            OP_ADD:                 alu_out = op_a + op_b;
            OP_SUB:                 alu_out = op_a - op_b;
            OP_AND:                 alu_out = op_a & op_b;
            OP_OR:                  alu_out = op_a | op_b;
            OP_XOR:                 alu_out = op_a ^ op_b;
            OP_ADDI, OP_LW, OP_SW:  alu_out = op_a + id_ex.imm;   // Also the byte address
            default:                alu_out = '0;
        endcase
    end

    assign branch_taken  = id_ex.valid && (id_ex.op == OP_BEQ) && (op_a == op_b);
    assign branch_target = id_ex.pc + {id_ex.imm[29:0], 2'b00};    // Word offset from BEQ

    always_comb begin
        ex_next            = '0;
        ex_next.valid      = id_ex.valid;
        ex_next.op         = id_ex.op;
        ex_next.rd         = id_ex.rd;
        ex_next.reg_write  = id_ex.reg_write; // Clear for BEQ and SW
        ex_next.mem_read   = id_ex.mem_read;
        ex_next.mem_write  = (id_ex.op == OP_SW);
        ex_next.alu_out    = alu_out;
        ex_next.store_data = op_b;            // SW data register sits in rs2
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ex_mem <= '0;
            held_q <= 1'b0;
        end else begin
            ex_mem <= stall ? '0 : ex_next;   // Bubble behind a load
            held_q <= stall;
        end
    end

    always_ff @(posedge clk) begin
        if (stall) begin
            hold_a <= op_a;
            hold_b <= op_b;
        end
    end

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`default_nettype none
`timescale 1ns/1ns

module mem_wb_stage #(
    parameter int XLEN       = 32,
    parameter int DMEM_WORDS = 64             // Power of two
) (
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire pipe_pkg::ex_mem_t ex_mem,
    output pipe_pkg::mem_wb_t      mem_wb
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    logic [XLEN-1:0]   dmem [DMEM_WORDS];
    logic [ADDR_W-1:0] word_idx;              // Word index that wraps at the depth
    logic [XLEN-1:0]   load_data;
    logic [XLEN-1:0]   wb_value;

    assign word_idx = ex_mem.alu_out[ADDR_W+1:2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ex_mem.valid && ex_mem.mem_write) begin
            dmem[word_idx] <= ex_mem.store_data;
        end
    end

    assign load_data = dmem[word_idx];        // Combinational read for LW
    assign wb_value  = ex_mem.mem_read ? load_data : ex_mem.alu_out;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.rd        <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.wb_data   <= wb_value;
        end
    end

endmodule

`default_nettype wire

// File: pipe_core_top.sv
`default_nettype none
`timescale 1ns/1ns

module pipe_core_top #(
    parameter int XLEN       = 32,
    parameter int DMEM_WORDS = 64
) (
    input  wire logic            clk,
    input  wire logic            reset_n,
    output pipe_pkg::word_t      fetch_pc,
    input  wire pipe_pkg::word_t fetch_instr,
    output logic                 wb_valid,    // One strobe per register write
    output pipe_pkg::reg_idx_t   wb_rd,
    output logic      [XLEN-1:0] wb_data
);
    import pipe_pkg::*;

    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    fwd_sel_e  fwd_a, fwd_b;
    logic      stall, flush, branch_taken;
    word_t     branch_target;
    reg_idx_t  rs1_addr, rs2_addr;
    word_t     rs1_data, rs2_data;

    assign wb_valid = mem_wb.valid && mem_wb.reg_write && (mem_wb.rd != 5'd0);
    assign wb_rd    = mem_wb.rd;
    assign wb_data  = mem_wb.wb_data;

    fetch_decode fetch_decode_i (
        .clk, .reset_n, .fetch_pc, .fetch_instr, .stall, .flush, .branch_target,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data, .id_ex
    );

    reg_file #(.XLEN(XLEN)) reg_file_i (
        .clk, .reset_n,
        .rd_addr_a (rs1_addr), .rd_addr_b (rs2_addr),
        .rd_data_a (rs1_data), .rd_data_b (rs2_data),
        .wr_en     (wb_valid), .wr_addr   (mem_wb.rd), .wr_data (mem_wb.wb_data)
    );

    execute_stage #(.XLEN(XLEN)) execute_stage_i (
        .clk, .reset_n, .id_ex, .fwd_a, .fwd_b, .ex_mem_fwd (ex_mem), .mem_wb,
        .stall, .branch_taken, .branch_target, .ex_mem
    );

    mem_wb_stage #(.XLEN(XLEN), .DMEM_WORDS(DMEM_WORDS)) mem_wb_stage_i (
        .clk, .reset_n, .ex_mem, .mem_wb
    );

    hazard_unit hazard_unit_i (
        .id_ex, .ex_mem, .mem_wb, .branch_taken, .fwd_a, .fwd_b, .stall, .flush
    );

endmodule

`default_nettype wire

// File: tb_pipe_core.sv
`default_nettype none
`timescale 1ns/1ns

module tb_pipe_core;
    import pipe_pkg::*;

    localparam int CLK_HALF    = 2;           // 4 ns period
    localparam int PROG_WORDS  = 64;
    localparam int DRAIN       = 6;           // Idle fetches before the pipe is empty
    localparam int TASK_CYCLES = 200;         // Per-test bound
    // Six tests of up to 40 instructions plus stalls, reset and drain, with a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic     clk = 1'b0;
    logic     reset_n;
    word_t    fetch_pc;
    word_t    fetch_instr;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    word_t    prog [PROG_WORDS];              // Program of the current test
    int       prog_len;
    word_t    prog_end;                       // First byte address past the program
    int       seed = 32'h02c62d2d;
    int       cycles = 0;
    int       errors, test_errors, tests_run, tests_failed;
    int       exp_stalls;
    string    cur_name;
    reg_idx_t exp_rd[$];
    word_t    exp_data[$];
    reg_idx_t got_rd[$];
    word_t    got_data[$];

    always #CLK_HALF clk = ~clk;

    // Instruction source answers in the same cycle and returns NOP past the end
    assign fetch_instr = (fetch_pc < prog_end) ? prog[fetch_pc[7:2]] : 32'd0;

    pipe_core_top #(.XLEN(32), .DMEM_WORDS(64)) dut_i (
        .clk, .reset_n, .fetch_pc, .fetch_instr, .wb_valid, .wb_rd, .wb_data
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    function automatic word_t enc_r(opcode_e op, int rd, int rs1, int rs2);
        return {op, rd[4:0], rs1[4:0], rs2[4:0], 13'd0};
    endfunction

    function automatic word_t enc_i(opcode_e op, int rd, int rs1, int imm);
        return {op, rd[4:0], rs1[4:0], imm[17:0]};    // SW data and BEQ reg in rd
    endfunction

    task automatic add_instr(word_t w);
        prog[prog_len] = w;
        prog_len++;
        prog_end = prog_end + 32'd4;
    endtask

    // Reset goes low here and the program is built while it is held
    task automatic begin_test(string name);
        cur_name    = name;
        test_errors = 0;
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        for (int i = 0; i < PROG_WORDS; i++) prog[i] = 32'd0;
        prog_len = 0;
        prog_end = 32'd0;
    endtask

    // Instruction-level model giving writes in program order and the load-use count
    task automatic run_model();
        word_t    r [32];
        word_t    m [64];
        instr_u   iw;
        opcode_e  op;
        reg_idx_t src1, src2, dst, prev_rd;
        logic     is_reg, u1, u2, wr, prev_load;
        word_t    a, b, imm, res, addr;
        int       pc, next_pc, steps, simm;
        exp_rd.delete();
        exp_data.delete();
        exp_stalls = 0;
        pc         = 0;
        steps      = 0;
        prev_load  = 1'b0;
        prev_rd    = '0;
        for (int i = 0; i < 32; i++) r[i] = '0;
        for (int i = 0; i < 64; i++) m[i] = '0;
        while (pc < prog_len && steps < 1000) begin
            iw     = prog[pc];
            op     = iw.r.op;
            is_reg = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
            src1   = iw.r.rs1;
            src2   = is_reg ? iw.r.rs2 : iw.i.rd;
            dst    = iw.r.rd;                 // Same field in both forms
            u1     = (op != OP_NOP);
            u2     = is_reg || (op == OP_SW) || (op == OP_BEQ);
            if (prev_load && prev_rd != 5'd0 &&
                ((u1 && src1 == prev_rd) || (u2 && src2 == prev_rd))) begin
                exp_stalls++;                 // Consumer right behind its load
            end
            a       = r[src1];
            b       = r[src2];
            imm     = {{14{iw.i.imm[17]}}, iw.i.imm};
            simm    = $signed(imm);
            addr    = a + imm;
            res     = '0;
            wr      = 1'b0;
            next_pc = pc + 1;
            case (op)
                OP_ADD:  begin res = a + b;          wr = 1'b1; end
                OP_SUB:  begin res = a - b;          wr = 1'b1; end
                OP_AND:  begin res = a & b;          wr = 1'b1; end
                OP_OR:   begin res = a | b;          wr = 1'b1; end
                OP_XOR:  begin res = a ^ b;          wr = 1'b1; end
                OP_ADDI: begin res = a + imm;        wr = 1'b1; end
                OP_LW:   begin res = m[addr[7:2]];   wr = 1'b1; end
                OP_SW:   m[addr[7:2]] = b;           // Word address wraps at 64
                OP_BEQ:  if (a == b) next_pc = pc + simm;
                default: ;
            endcase
            if (wr && dst != 5'd0) begin
                r[dst] = res;
                exp_rd.push_back(dst);
                exp_data.push_back(res);
            end
            prev_load = (op == OP_LW);
            prev_rd   = dst;
            pc        = next_pc;
            steps++;
        end
    endtask

    task automatic run_program();
        int    n, idle, repeats;
        word_t last_pc;
        run_model();
        got_rd.delete();
        got_data.delete();
        @(posedge clk);
        #1;
        assert (wb_valid == 1'b0 && fetch_pc == 32'd0) else begin
            $display("FAILED %s: in reset expected wb_valid 0 fetch_pc 0, actual %b %h",
                     cur_name, wb_valid, fetch_pc);
            test_errors++;
        end
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        assert (fetch_pc == 32'd0) else begin
            $display("FAILED %s: fetch_pc after reset expected 0, actual %h",
                     cur_name, fetch_pc);
            test_errors++;
        end
        n       = 0;
        idle    = 0;
        repeats = 0;
        last_pc = '0;
        while (idle < DRAIN && n < TASK_CYCLES) begin
            @(negedge clk);                   // Outputs settled mid-cycle
            n++;
            if (wb_valid) begin
                got_rd.push_back(wb_rd);
                got_data.push_back(wb_data);
            end
            if (n > 1 && fetch_pc == last_pc) repeats++;
            last_pc = fetch_pc;
            if (fetch_pc >= prog_end) idle++;
            else idle = 0;
        end
        assert (n < TASK_CYCLES) else begin
            $display("%s: pipeline did not drain within %0d cycles", cur_name, TASK_CYCLES);
            test_errors++;
        end
        assert (got_rd.size() == exp_rd.size()) else begin
            $display("%s: expected %0d register writes but the DUT made %0d",
                     cur_name, exp_rd.size(), got_rd.size());
            test_errors++;
        end
        for (int i = 0; i < exp_rd.size() && i < got_rd.size(); i++) begin
            assert (got_rd[i] == exp_rd[i] && got_data[i] == exp_data[i]) else begin
                $display("FAILED %s: write %0d expected x%0d = %h, actual x%0d = %h",
                         cur_name, i, exp_rd[i], exp_data[i], got_rd[i], got_data[i]);
                test_errors++;
            end
        end
        assert (repeats == exp_stalls) else begin
            $display("FAILED %s: fetch_pc holds expected %0d, actual %0d",
                     cur_name, exp_stalls, repeats);
            test_errors++;
        end
        tests_run++;
        if (test_errors != 0) tests_failed++;
        errors += test_errors;
        $display("%s: %0d writes, %0d stalls, %0d errors",
                 cur_name, got_rd.size(), repeats, test_errors);
    endtask

    task automatic test_reset();
        begin_test("reset");                  // Empty program that fetches only NOPs
        run_program();
    endtask

    task automatic test_forwarding();
        begin_test("forwarding");
        add_instr(enc_i(OP_ADDI, 1, 0, 5));
        add_instr(enc_i(OP_ADDI, 2, 1, 3));   // From EX/MEM
        add_instr(enc_r(OP_ADD, 3, 1, 2));    // MEM/WB on rs1, EX/MEM on rs2
        add_instr(enc_r(OP_SUB, 4, 3, 1));
        add_instr(enc_r(OP_XOR, 5, 4, 3));
        add_instr(enc_i(OP_ADDI, 6, 0, 7));
        add_instr(enc_i(OP_ADDI, 6, 6, 1));
        add_instr(enc_r(OP_ADD, 7, 6, 6));    // Both stages hold x6 and the newer one counts
        add_instr(enc_r(OP_AND, 8, 7, 5));
        add_instr(enc_r(OP_OR, 9, 8, 2));
        run_program();
    endtask

    task automatic test_load_use();
        begin_test("load_use");
        add_instr(enc_i(OP_ADDI, 1, 0, 100));
        add_instr(enc_i(OP_ADDI, 2, 0, 8));
        add_instr(enc_i(OP_SW, 1, 2, 0));
        add_instr(enc_i(OP_LW, 3, 2, 0));
        add_instr(enc_r(OP_ADD, 4, 3, 1));    // Loaded value on rs1
        add_instr(enc_i(OP_LW, 5, 2, 0));
        add_instr(enc_r(OP_SUB, 6, 1, 5));    // Loaded value on rs2
        add_instr(enc_i(OP_ADDI, 7, 0, -5));
        add_instr(enc_i(OP_SW, 7, 2, 4));
        add_instr(enc_i(OP_LW, 8, 2, 4));
        add_instr(enc_i(OP_SW, 8, 2, 8));     // Loaded value as store data
        add_instr(enc_i(OP_LW, 9, 2, 8));
        run_program();
    endtask

    task automatic test_branch();
        begin_test("branch");
        add_instr(enc_i(OP_ADDI, 1, 0, 9));
        add_instr(enc_i(OP_ADDI, 2, 0, 9));
        add_instr(enc_i(OP_BEQ, 1, 2, 3));    // Taken with both operands forwarded
        add_instr(enc_i(OP_ADDI, 3, 0, 1));
        add_instr(enc_i(OP_ADDI, 4, 0, 2));
        add_instr(enc_i(OP_ADDI, 5, 0, 3));   // Branch target
        add_instr(enc_i(OP_BEQ, 5, 1, 2));    // Not taken
        add_instr(enc_i(OP_ADDI, 6, 0, 4));
        add_instr(enc_r(OP_ADD, 7, 5, 6));
        run_program();
    endtask

    task automatic test_reg_zero();
        begin_test("reg_zero");
        add_instr(enc_i(OP_ADDI, 0, 0, 55));
        add_instr(enc_r(OP_ADD, 1, 0, 0));    // x0 in EX/MEM must not forward
        add_instr(enc_i(OP_ADDI, 2, 0, 12));
        add_instr(enc_r(OP_ADD, 0, 2, 2));
        add_instr(enc_i(OP_ADDI, 3, 0, 1));
        add_instr(enc_r(OP_ADD, 4, 0, 2));
        run_program();
    endtask

    task automatic test_random();
        int r;
        int k;
        begin_test("random_alu");
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            k = $unsigned($random(seed)) % 6;
            if (k == 5) begin
                add_instr(enc_i(OP_ADDI, r & 7, (r >> 3) & 7, r >>> 9));
            end else begin
                add_instr(enc_r(opcode_e'(k + 1), r & 7, (r >> 3) & 7, (r >> 6) & 7));
            end
        end
        run_program();
    endtask

    initial begin
        reset_n      = 1'b0;
        prog_len     = 0;
        prog_end     = 32'd0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_reset();
        test_forwarding();
        test_load_use();
        test_branch();
        test_reg_zero();
        test_random();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
pipe_pkg.sv
hazard_unit.sv
reg_file.sv
fetch_decode.sv
execute_stage.sv
mem_wb_stage.sv
pipe_core_top.sv
tb_pipe_core.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_pipe_core
FILELIST = build.f
LOG      = sim.log
PASS_MSG = No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
